// ==== common/aes_pkg.sv ====
package aes_pkg;

	typedef logic [127:0] aes_block_t;   // first FIPS byte in [127:120]
	typedef logic [31:0] aes_word_t;     // one state column
	typedef logic [7:0] aes_byte_t;
	typedef logic [3:0] round_idx_t;     // 0 to 10

	localparam round_idx_t num_rounds = 4'd10;   // AES-128 only

	// round constants, entry i feeds round key i+1
	localparam logic [0:9][7:0] rcon = {
		8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	};

	// register map, word 0 of a group is the top 32 bits
	localparam logic [7:0] reg_ctrl = 8'h00;
	localparam logic [7:0] reg_status = 8'h04;
	localparam logic [7:0] reg_key0 = 8'h10;
	localparam logic [7:0] reg_key1 = 8'h14;
	localparam logic [7:0] reg_key2 = 8'h18;
	localparam logic [7:0] reg_key3 = 8'h1c;
	localparam logic [7:0] reg_pt0 = 8'h20;
	localparam logic [7:0] reg_pt1 = 8'h24;
	localparam logic [7:0] reg_pt2 = 8'h28;
	localparam logic [7:0] reg_pt3 = 8'h2c;
	localparam logic [7:0] reg_ct0 = 8'h30;
	localparam logic [7:0] reg_ct1 = 8'h34;
	localparam logic [7:0] reg_ct2 = 8'h38;
	localparam logic [7:0] reg_ct3 = 8'h3c;

	localparam logic [1:0] axil_okay = 2'b00;
	localparam logic [1:0] axil_slverr = 2'b10;

	typedef struct packed {
		logic       en;
		round_idx_t idx;
		aes_block_t data;
	} rkey_wr_t;

	typedef struct packed {
		logic [7:0]  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;    // ignored, full-word writes only
		logic        wvalid;
		logic        bready;
		logic [7:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

	// forward sbox, row 0x0_ first
	localparam logic [0:255][7:0] sbox_table = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic aes_byte_t sbox(aes_byte_t b);
		return sbox_table[b];
	endfunction

	// multiply by x in GF(2^8), poly 0x11b
	function automatic aes_byte_t gm2(aes_byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic aes_byte_t gm3(aes_byte_t b);
		return gm2(b) ^ b;
	endfunction

	function automatic aes_block_t sub_bytes(aes_block_t blk);
		logic [0:15][7:0] s;
		s = blk;
		for (int i = 0; i < 16; i++)
			s[i] = sbox(s[i]);
		return s;
	endfunction

	// byte 4*c+r holds row r of column c
	function automatic aes_block_t shift_rows(aes_block_t blk);
		logic [0:15][7:0] s;
		logic [0:15][7:0] o;
		s = blk;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				o[4*c+r] = s[4*((c+r)%4)+r];   // row r rotates left by r
		return o;
	endfunction

	function automatic aes_block_t mix_columns(aes_block_t blk);
		logic [0:15][7:0] s;
		logic [0:15][7:0] o;
		s = blk;
		for (int c = 0; c < 4; c++) begin
			o[4*c]   = gm2(s[4*c]) ^ gm3(s[4*c+1]) ^ s[4*c+2] ^ s[4*c+3];
			o[4*c+1] = s[4*c] ^ gm2(s[4*c+1]) ^ gm3(s[4*c+2]) ^ s[4*c+3];
			o[4*c+2] = s[4*c] ^ s[4*c+1] ^ gm2(s[4*c+2]) ^ gm3(s[4*c+3]);
			o[4*c+3] = gm3(s[4*c]) ^ s[4*c+1] ^ s[4*c+2] ^ gm2(s[4*c+3]);
		end
		return o;
	endfunction

	function automatic aes_word_t sub_word(aes_word_t w);
		logic [0:3][7:0] v;
		v = w;
		for (int i = 0; i < 4; i++)
			v[i] = sbox(v[i]);
		return v;
	endfunction

	function automatic aes_word_t rot_word(aes_word_t w);
		return {w[23:0], w[31:24]};   // top byte moves to the bottom
	endfunction

endpackage

// ==== aes/aes_round_key_mem.sv ====
`timescale 1ns/1ps

module aes_round_key_mem
	import aes_pkg::*;
(
	input  logic       clk,
	input  rkey_wr_t   wr,       // from the key expander
	input  round_idx_t rd_idx,   // from the cipher
	output aes_block_t rd_key    // one cycle after rd_idx
);

	aes_block_t mem [0:num_rounds];   // rounds 0 to 10

	always_ff @(posedge clk) begin
		if (wr.en)
			mem[wr.idx] <= wr.data;
	end

	// registered read port
	always_ff @(posedge clk) begin
		rd_key <= mem[rd_idx];
	end

endmodule

// ==== aes/aes_key_expand.sv ====
`timescale 1ns/1ps

module aes_key_expand
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       key_load,    // one-cycle pulse, already gated
	input  aes_block_t key,
	output rkey_wr_t   rkey_wr,     // to the round-key memory
	output logic       key_ready,   // all eleven keys stored
	output logic       key_busy
);

	aes_word_t  w0;   // current round key, w0 is the top word
	aes_word_t  w1;
	aes_word_t  w2;
	aes_word_t  w3;
	aes_word_t  n0;   // next round key
	aes_word_t  n1;
	aes_word_t  n2;
	aes_word_t  n3;
	aes_word_t  temp;
	aes_byte_t  rc;
	round_idx_t idx;  // round of the key now in w0..w3

	// no constant past round 10, that key is the last one
	assign rc = (idx < num_rounds) ? rcon[idx] : 8'h00;

	// standard AES-128 schedule step
	assign temp = sub_word(rot_word(w3)) ^ {rc, 24'h000000};
	assign n0 = w0 ^ temp;
	assign n1 = w1 ^ n0;
	assign n2 = w2 ^ n1;
	assign n3 = w3 ^ n2;

	always_ff @(posedge clk) begin
		if (reset) begin
			key_busy <= 1'b0;
			key_ready <= 1'b0;
			idx <= '0;
		end else if (key_load) begin
			key_busy <= 1'b1;
			key_ready <= 1'b0;   // old schedule no longer valid
			idx <= '0;
		end else if (key_busy) begin
			idx <= idx + 4'd1;
			if (idx == num_rounds) begin   // round 10 written this cycle
				key_busy <= 1'b0;
				key_ready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (key_load)
			{w0, w1, w2, w3} <= key;   // round 0 is the key itself
		else if (key_busy)
			{w0, w1, w2, w3} <= {n0, n1, n2, n3};
	end

	// one memory write per busy cycle
	assign rkey_wr.en = key_busy;
	assign rkey_wr.idx = idx;
	assign rkey_wr.data = {w0, w1, w2, w3};

endmodule

// ==== aes/aes_cipher.sv ====
`timescale 1ns/1ps

module aes_cipher
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       start,        // one-cycle pulse
	input  aes_block_t plaintext,
	input  aes_block_t rd_key,       // key for rd_idx of the cycle before
	output round_idx_t rd_idx,
	output aes_block_t ciphertext,   // valid from done on
	output logic       busy,
	output logic       done
);

	logic       key_rd_en;   // a round-key read is issued this cycle
	round_idx_t key_idx;
	logic       round_en;    // rd_key holds the key of round_no
	round_idx_t round_no;    // trails key_idx by one cycle
	aes_block_t state;
	aes_block_t state_sr;    // after SubBytes and ShiftRows
	aes_block_t state_mc;    // plus MixColumns

	assign state_sr = shift_rows(sub_bytes(state));
	assign state_mc = mix_columns(state_sr);

	assign busy = key_rd_en | round_en;
	assign rd_idx = key_idx;
	assign ciphertext = state;

	// key index counter, issues reads 0..10 back to back
	always_ff @(posedge clk) begin
		if (reset) begin
			key_rd_en <= 1'b0;
			key_idx <= '0;
		end else if (start && !busy) begin
			key_rd_en <= 1'b1;
			key_idx <= '0;
		end else if (key_rd_en) begin
			if (key_idx == num_rounds)
				key_rd_en <= 1'b0;   // last key read issued
			else
				key_idx <= key_idx + 4'd1;
		end
	end

	// round counter follows the key reads
	always_ff @(posedge clk) begin
		if (reset) begin
			round_en <= 1'b0;
			round_no <= '0;
			done <= 1'b0;
		end else begin
			round_en <= key_rd_en;
			round_no <= key_idx;
			done <= round_en && (round_no == num_rounds);   // one cycle after round 10
		end
	end

	// the block is captured at start, so the register slave
	// is free to take the next plaintext while we run
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			state <= plaintext;
		end else if (round_en) begin
			if (round_no == '0)
				state <= state ^ rd_key;      // initial AddRoundKey
			else if (round_no == num_rounds)
				state <= state_sr ^ rd_key;   // final round skips MixColumns
			else
				state <= state_mc ^ rd_key;
		end
	end

endmodule

// ==== logic/axil_regs.sv ====
`timescale 1ns/1ps

module axil_regs
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  axil_req_t  req,
	output axil_rsp_t  rsp,
	output aes_block_t key,
	output aes_block_t plaintext,
	output logic       key_load,      // pulse to the key expander
	output logic       start,         // pulse to the cipher
	input  logic       key_ready,
	input  logic       key_busy,
	input  logic       cipher_busy,
	input  logic       cipher_done,
	input  aes_block_t ciphertext
);

	logic        wr_fire;   // AW and W taken together
	logic        rd_fire;
	logic        busy;      // either engine running
	logic        done;      // sticky
	logic [1:0]  wr_word;   // word select within a 128-bit group
	logic [1:0]  rd_word;
	logic [31:0] rd_val;
	aes_block_t  key_q;
	aes_block_t  pt_q;
	aes_block_t  ct_q;
	logic        bvalid;
	logic        rvalid;
	logic [1:0]  bresp;
	logic [1:0]  rresp;
	logic [31:0] rdata;

	function automatic logic is_mapped(logic [7:0] addr);
		case (addr)
			reg_ctrl, reg_status,
			reg_key0, reg_key1, reg_key2, reg_key3,
			reg_pt0, reg_pt1, reg_pt2, reg_pt3,
			reg_ct0, reg_ct1, reg_ct2, reg_ct3:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// word 0 is the top word of the block
	function automatic logic [31:0] word_of(aes_block_t blk, logic [1:0] sel);
		return blk[32*(3 - sel) +: 32];
	endfunction

	assign busy = key_busy | cipher_busy;
	assign wr_fire = req.awvalid & req.wvalid & ~bvalid;   // blocked while a response waits
	assign rd_fire = req.arvalid & ~rvalid;
	assign wr_word = req.awaddr[3:2];
	assign rd_word = req.araddr[3:2];

	assign key = key_q;
	assign plaintext = pt_q;

	// read mux, ctrl and unmapped read as zero
	always_comb begin
		case (req.araddr)
			reg_status:
				rd_val = {29'd0, done, busy, key_ready};
			reg_key0, reg_key1, reg_key2, reg_key3:
				rd_val = word_of(key_q, rd_word);
			reg_pt0, reg_pt1, reg_pt2, reg_pt3:
				rd_val = word_of(pt_q, rd_word);
			reg_ct0, reg_ct1, reg_ct2, reg_ct3:
				rd_val = word_of(ct_q, rd_word);
			default:
				rd_val = 32'd0;
		endcase
	end

	// key and plaintext words, status and ct writes are ignored
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			case (req.awaddr)
				reg_key0, reg_key1, reg_key2, reg_key3:
					key_q[32*(3 - wr_word) +: 32] <= req.wdata;
				reg_pt0, reg_pt1, reg_pt2, reg_pt3:
					pt_q[32*(3 - wr_word) +: 32] <= req.wdata;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			key_load <= 1'b0;
			start <= 1'b0;
			done <= 1'b0;
			ct_q <= '0;
		end else begin
			key_load <= 1'b0;
			start <= 1'b0;
			if (bvalid && req.bready)
				bvalid <= 1'b0;
			if (wr_fire)
				bvalid <= 1'b1;
			if (rvalid && req.rready)
				rvalid <= 1'b0;
			if (rd_fire)
				rvalid <= 1'b1;
			// ctrl pulses dropped while an engine runs
			if (wr_fire && req.awaddr == reg_ctrl && !busy) begin
				key_load <= req.wdata[0];
				start <= req.wdata[1] & ~req.wdata[0] & key_ready;   // not with a key reload
			end
			if (cipher_done) begin
				done <= 1'b1;
				ct_q <= ciphertext;
			end
			if (start || key_load)
				done <= 1'b0;   // a new key also makes the old result stale
		end
	end

	// response payload held with its valid
	always_ff @(posedge clk) begin
		if (wr_fire)
			bresp <= is_mapped(req.awaddr) ? axil_okay : axil_slverr;
		if (rd_fire) begin
			rdata <= rd_val;
			rresp <= is_mapped(req.araddr) ? axil_okay : axil_slverr;
		end
	end

	assign rsp.awready = req.wvalid & ~bvalid;
	assign rsp.wready = req.awvalid & ~bvalid;
	assign rsp.bresp = bresp;
	assign rsp.bvalid = bvalid;
	assign rsp.arready = ~rvalid;
	assign rsp.rdata = rdata;
	assign rsp.rresp = rresp;
	assign rsp.rvalid = rvalid;

endmodule

// ==== logic/aes_top.sv ====
`timescale 1ns/1ps

module aes_top
	import aes_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp
);

	aes_block_t key;
	aes_block_t plaintext;
	aes_block_t ciphertext;
	aes_block_t rd_key;
	round_idx_t rd_idx;
	rkey_wr_t   rkey_wr;
	logic       key_load;
	logic       start;
	logic       key_ready;
	logic       key_busy;
	logic       cipher_busy;
	logic       cipher_done;

	axil_regs i_regs (
		.clk         (clk),
		.reset       (reset),
		.req         (axil_req),
		.rsp         (axil_rsp),
		.key         (key),
		.plaintext   (plaintext),
		.key_load    (key_load),
		.start       (start),
		.key_ready   (key_ready),
		.key_busy    (key_busy),
		.cipher_busy (cipher_busy),
		.cipher_done (cipher_done),
		.ciphertext  (ciphertext)
	);

	aes_key_expand i_key_expand (
		.clk       (clk),
		.reset     (reset),
		.key_load  (key_load),
		.key       (key),
		.rkey_wr   (rkey_wr),
		.key_ready (key_ready),
		.key_busy  (key_busy)
	);

	aes_round_key_mem i_rkey_mem (
		.clk    (clk),
		.wr     (rkey_wr),
		.rd_idx (rd_idx),
		.rd_key (rd_key)
	);

	aes_cipher i_cipher (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.plaintext  (plaintext),
		.rd_key     (rd_key),
		.rd_idx     (rd_idx),
		.ciphertext (ciphertext),
		.busy       (cipher_busy),
		.done       (cipher_done)
	);

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #4 clk = ~clk;   // 8 ns period

endmodule

// ==== test/aes_chk.sv ====
`timescale 1ns/1ps

module aes_chk
	import aes_pkg::*;
(
	input logic      clk,
	input logic      reset,
	input axil_req_t req,
	input axil_rsp_t rsp,
	input logic      done,   // sticky status bit
	input logic      busy    // either engine running
);

	// write response waits for the master
	a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		rsp.bvalid && !req.bready |=> rsp.bvalid)
		else $error("bvalid dropped before bready");

	// read data frozen while stalled
	a_rdata_stable: assert property (@(posedge clk) disable iff (reset)
		rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
		else $error("rdata or rvalid changed while rready was low");

	a_done_not_busy: assert property (@(posedge clk) disable iff (reset)
		!(done && busy))
		else $error("status done set while busy");

endmodule

// ==== test/tb_aes.sv ====
`timescale 1ns/1ps

module tb_aes
	import aes_pkg::*;
();

	localparam int max_cycles = 20000;   // whole test list plus margin
	localparam int max_polls = 40;       // status polls before giving up
	localparam int stall_cycles = 6;     // rready held low this long

	// FIPS-197 appendix C.1 and appendix B vectors
	localparam logic [127:0] kat1_key = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [127:0] kat1_pt = 128'h00112233445566778899aabbccddeeff;
	localparam logic [127:0] kat1_ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam logic [127:0] kat2_key = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam logic [127:0] kat2_pt = 128'h3243f6a8885a308d313198a2e0370734;
	localparam logic [127:0] kat2_ct = 128'h3925841d02dc09fbdc118597196a0b32;

	logic        clk;
	logic        reset;
	axil_req_t   req;
	axil_rsp_t   rsp;
	logic [31:0] rng_state;
	int          cycle_count = 0;

	tb_clock i_clock (.clk(clk));

	aes_top i_dut (
		.clk      (clk),
		.reset    (reset),
		.axil_req (req),
		.axil_rsp (rsp)
	);

	bind axil_regs aes_chk i_chk (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.rsp   (rsp),
		.done  (done),
		.busy  (busy)
	);

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// word 0 is the top 32 bits
	function automatic logic [31:0] block_word(logic [127:0] blk, int i);
		return blk[32*(3 - i) +: 32];
	endfunction

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("error at time %0t: %s, got %h expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	// hang guard
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > max_cycles) begin
			$display("timeout: the tests did not finish within %0d cycles", max_cycles);
			abort_run();
		end
	end

	// AW and W together, bready stays high
	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(negedge clk);
		req.awaddr = addr;
		req.awvalid = 1'b1;
		req.wdata = data;
		req.wstrb = 4'hf;
		req.wvalid = 1'b1;
		@(negedge clk);
		while (!rsp.bvalid)
			@(negedge clk);
		resp = rsp.bresp;
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(negedge clk);
		req.araddr = addr;
		req.arvalid = 1'b1;
		@(negedge clk);
		while (!rsp.rvalid)
			@(negedge clk);
		data = rsp.rdata;
		resp = rsp.rresp;
		req.arvalid = 1'b0;   // rvalid clears on the next edge
	endtask

	task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axil_write(addr, data, resp);
		check_eq({30'd0, resp}, {30'd0, axil_okay}, "write response");
	endtask

	task automatic read_ok(input logic [7:0] addr, output logic [31:0] data);
		logic [1:0] resp;
		axil_read(addr, data, resp);
		check_eq({30'd0, resp}, {30'd0, axil_okay}, "read response");
	endtask

	task automatic write_block(input logic [7:0] base, input logic [127:0] blk);
		int i;
		for (i = 0; i < 4; i++)
			write_ok(base + {i[5:0], 2'b00}, block_word(blk, i));
	endtask

	task automatic read_block(input logic [7:0] base, output logic [127:0] blk);
		logic [31:0] d;
		int i;
		for (i = 0; i < 4; i++) begin
			read_ok(base + {i[5:0], 2'b00}, d);
			blk[32*(3 - i) +: 32] = d;
		end
	endtask

	task automatic check_block(input logic [127:0] got, input logic [127:0] exp,
			input string what);
		int i;
		for (i = 0; i < 4; i++)
			check_eq(block_word(got, i), block_word(exp, i), what);
	endtask

	// poll one status bit until it is set
	task automatic wait_status_bit(input int bit_no, input string what);
		logic [31:0] st;
		int polls;
		polls = 0;
		read_ok(reg_status, st);
		while (st[bit_no] !== 1'b1) begin
			polls++;
			if (polls >= max_polls) begin
				$display("%s did not show up in status after %0d polls", what, max_polls);
				abort_run();
			end else begin
				read_ok(reg_status, st);
			end
		end
	endtask

	task automatic load_key(input logic [127:0] key);
		write_block(reg_key0, key);
		write_ok(reg_ctrl, 32'h1);   // key_load
		wait_status_bit(0, "key_ready");
	endtask

	task automatic run_cipher(input logic [127:0] pt, output logic [127:0] ct);
		write_block(reg_pt0, pt);
		write_ok(reg_ctrl, 32'h2);   // start
		wait_status_bit(2, "done");
		read_block(reg_ct0, ct);
	endtask

	task automatic test_reset_state();
		logic [31:0]  st;
		logic [127:0] ct;
		read_ok(reg_status, st);
		check_eq(st, 32'h0, "status after reset");
		read_block(reg_ct0, ct);
		check_block(ct, 128'h0, "ciphertext after reset");
	endtask

	// no key yet, start must be dropped
	task automatic test_start_without_key();
		logic [31:0] st;
		int i;
		write_ok(reg_ctrl, 32'h2);
		for (i = 0; i < 5; i++) begin
			read_ok(reg_status, st);
			check_eq(st, 32'h0, "status after start without key");
		end
	endtask

	task automatic test_register_map();
		logic [31:0] vals [0:7];
		logic [31:0] d;
		logic [1:0]  resp;
		int i;
		for (i = 0; i < 8; i++) begin
			rng_state = xorshift32(rng_state);
			vals[i] = rng_state;
			write_ok(reg_key0 + {i[5:0], 2'b00}, vals[i]);   // key0..3 then pt0..3
		end
		for (i = 0; i < 8; i++) begin
			read_ok(reg_key0 + {i[5:0], 2'b00}, d);
			check_eq(d, vals[i], "register readback");
		end
		axil_write(8'h40, 32'hdeadbeef, resp);
		check_eq({30'd0, resp}, {30'd0, axil_slverr}, "unmapped write response");
		axil_read(8'h44, d, resp);
		check_eq({30'd0, resp}, {30'd0, axil_slverr}, "unmapped read response");
		axil_read(reg_ctrl, d, resp);
		check_eq({30'd0, resp}, {30'd0, axil_okay}, "ctrl read response");
		check_eq(d, 32'h0, "ctrl read value");
		read_ok(reg_key0, d);
		check_eq(d, vals[0], "key0 after unmapped write");
	endtask

	task automatic test_known_answer(input logic [127:0] key, input logic [127:0] pt,
			input logic [127:0] exp, input string what);
		logic [127:0] ct;
		load_key(key);
		run_cipher(pt, ct);
		check_block(ct, exp, what);
	endtask

	// same block twice under one key, done cleared by the second start
	task automatic test_repeat_and_done();
		logic [127:0] first;
		logic [127:0] second;
		logic [31:0]  st;
		load_key(kat1_key);
		run_cipher(kat1_pt, first);
		check_block(first, kat1_ct, "first encryption");
		write_ok(reg_ctrl, 32'h2);
		read_ok(reg_status, st);
		check_eq({31'd0, st[2]}, 32'h0, "done after new start");
		check_eq({31'd0, st[1]}, 32'h1, "busy after new start");
		wait_status_bit(2, "done");
		read_block(reg_ct0, second);
		check_block(second, kat1_ct, "second encryption");
	endtask

	// ct1 read with rready held low
	task automatic test_read_backpressure();
		logic [31:0] first;
		int i;
		@(negedge clk);
		req.rready = 1'b0;
		req.araddr = reg_ct1;
		req.arvalid = 1'b1;
		@(negedge clk);
		while (!rsp.rvalid)
			@(negedge clk);
		req.arvalid = 1'b0;
		first = rsp.rdata;
		check_eq({30'd0, rsp.rresp}, {30'd0, axil_okay}, "stalled read response");
		check_eq(first, block_word(kat1_ct, 1), "stalled ciphertext word");
		for (i = 0; i < stall_cycles; i++) begin
			@(negedge clk);
			check_eq({31'd0, rsp.rvalid}, 32'h1, "rvalid during stall");
			check_eq({31'd0, rsp.arready}, 32'h0, "arready during stall");
			check_eq(rsp.rdata, block_word(kat1_ct, 1), "rdata during stall");
		end
		req.rready = 1'b1;
		@(negedge clk);
		check_eq({31'd0, rsp.rvalid}, 32'h0, "rvalid after rready");
		check_eq({31'd0, rsp.arready}, 32'h1, "arready after rready");
	endtask

	// pt0 write with bready held low, a pt1 write waits behind it
	task automatic test_write_backpressure();
		logic [31:0] val_a;
		logic [31:0] val_b;
		logic [31:0] d;
		int i;
		rng_state = xorshift32(rng_state);
		val_a = rng_state;
		rng_state = xorshift32(rng_state);
		val_b = rng_state;
		@(negedge clk);
		req.bready = 1'b0;
		req.awaddr = reg_pt0;
		req.awvalid = 1'b1;
		req.wdata = val_a;
		req.wstrb = 4'hf;
		req.wvalid = 1'b1;
		@(negedge clk);
		while (!rsp.bvalid)
			@(negedge clk);
		check_eq({30'd0, rsp.bresp}, {30'd0, axil_okay}, "stalled write response");
		req.awaddr = reg_pt1;   // next write queued behind the response
		req.wdata = val_b;
		for (i = 0; i < stall_cycles; i++) begin
			@(negedge clk);
			check_eq({31'd0, rsp.bvalid}, 32'h1, "bvalid during stall");
			check_eq({30'd0, rsp.awready, rsp.wready}, 32'h0, "aw and w ready during stall");
		end
		req.bready = 1'b1;
		@(negedge clk);
		check_eq({31'd0, rsp.bvalid}, 32'h0, "bvalid after bready");
		check_eq({30'd0, rsp.awready, rsp.wready}, 32'h3, "aw and w ready after bready");
		@(negedge clk);
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		check_eq({31'd0, rsp.bvalid}, 32'h1, "queued write response valid");
		check_eq({30'd0, rsp.bresp}, {30'd0, axil_okay}, "queued write response");
		read_ok(reg_pt0, d);
		check_eq(d, val_a, "pt0 after stalled write");
		read_ok(reg_pt1, d);
		check_eq(d, val_b, "pt1 after queued write");
	endtask

	initial begin
		req = '0;
		req.bready = 1'b1;
		req.rready = 1'b1;
		reset = 1'b1;
		rng_state = 32'd84188;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_reset_state();
		test_start_without_key();   // must run before any key load
		test_register_map();
		test_known_answer(kat1_key, kat1_pt, kat1_ct, "known answer 1");
		test_known_answer(kat2_key, kat2_pt, kat2_ct, "known answer 2");   // also a key reload
		test_repeat_and_done();
		test_read_backpressure();
		test_write_backpressure();

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== project.f ====
common/aes_pkg.sv
aes/aes_round_key_mem.sv
aes/aes_key_expand.sv
aes/aes_cipher.sv
logic/axil_regs.sv
logic/aes_top.sv
test/tb_clock.sv
test/aes_chk.sv
test/tb_aes.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the AES testbench with Verilator and run it
# exit status is nonzero when the simulation fails
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_aes \
	--Mdir obj_dir \
	-o tb_aes_sim

./obj_dir/tb_aes_sim
